// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    parameter int xlen          = 32;
    parameter int hist_w        = 16;
    parameter int tag_w         = 10;
    parameter int partial_tag_w = 6;   // upper tag bits used at lookup
    parameter int btb_tag_w     = 22;

    parameter int default_base_entries   = 512;
    parameter int default_tagged_entries = 256;
    parameter int default_btb_entries    = 256;
    parameter int default_ras_depth      = 32;

    typedef logic [xlen-1:0]      addr_t;
    typedef logic [hist_w-1:0]    hist_t;
    typedef logic [1:0]           ctr_t;
    typedef logic [tag_w-1:0]     tag_t;
    typedef logic [btb_tag_w-1:0] btb_tag_t;
    typedef logic [8:0]           bidx_t;   // base table index
    typedef logic [7:0]           tidx_t;   // tagged table index
    typedef logic [7:0]           btb_idx_t;

    typedef enum logic [1:0] {
        prov_base = 2'b00,
        prov_t0   = 2'b01,
        prov_t1   = 2'b10
    } provider_e;

    localparam ctr_t ctr_weak_nt = 2'b01;

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // t0 folds the short history, t1 the long one
    function automatic tidx_t t0_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic tidx_t t1_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic tag_t t0_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic tag_t t1_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ {2'b00, h[7:0]};
    endfunction

    function automatic bidx_t base_index(addr_t pc);
        return pc[9:1];
    endfunction

    function automatic btb_idx_t btb_index(addr_t pc);
        return pc[9:2];
    endfunction

    function automatic btb_tag_t btb_tag(addr_t pc);
        return pc[31:10];
    endfunction

    // 2-bit saturating step toward the outcome
    function automatic ctr_t ctr_step(ctr_t c, logic taken);
        if (taken)
            return (c == 2'b11) ? c : c + 2'b01;
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

endpackage

// ==== common/tage_upd_if.sv ====
interface tage_upd_if;

    bpu_pkg::tidx_t upd_index;
    bpu_pkg::tag_t  upd_tag;
    logic           upd_taken;
    logic           train;       // saturating step
    logic           set_strong;  // jump to strong state
    logic           allocate;    // new tag, weak counter
    logic           upd_tag_hit; // full tag compare at upd_index

    modport ctrl (
        output upd_index,
        output upd_tag,
        output upd_taken,
        output train,
        output set_strong,
        output allocate,
        input  upd_tag_hit
    );

    modport tbl (
        input  upd_index,
        input  upd_tag,
        input  upd_taken,
        input  train,
        input  set_strong,
        input  allocate,
        output upd_tag_hit
    );

endinterface

// ==== tage/tage_base_table.sv ====
module tage_base_table #(
    parameter int entries = bpu_pkg::default_base_entries
) (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::bidx_t lookup_index_i,
    output logic           ctr_msb_o,
    input  logic           upd_valid_i,
    input  bpu_pkg::bidx_t upd_index_i,
    input  logic           upd_taken_i
);

    bpu_pkg::ctr_t ctr_q [entries];

    assign ctr_msb_o = ctr_q[lookup_index_i][1];   // msb is the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++)
                ctr_q[i] <= bpu_pkg::ctr_weak_nt;
        end else if (upd_valid_i) begin
            ctr_q[upd_index_i] <= bpu_pkg::ctr_step(ctr_q[upd_index_i], upd_taken_i);
        end
    end

endmodule

// ==== tage/tage_tagged_table.sv ====
module tage_tagged_table #(
    parameter int entries = bpu_pkg::default_tagged_entries
) (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::tidx_t lookup_index_i,
    input  bpu_pkg::tag_t  lookup_tag_i,
    output logic           hit_o,
    output logic           ctr_msb_o,
    tage_upd_if.tbl        upd
);

    localparam int tag_hi = bpu_pkg::tag_w - 1;
    localparam int tag_lo = bpu_pkg::tag_w - bpu_pkg::partial_tag_w;

    bpu_pkg::tag_t tag_q [entries];
    bpu_pkg::ctr_t ctr_q [entries];
    bpu_pkg::tag_t lookup_entry_tag;

    assign lookup_entry_tag = tag_q[lookup_index_i];

    // partial compare on the lookup path
    assign hit_o     = (lookup_entry_tag[tag_hi:tag_lo] == lookup_tag_i[tag_hi:tag_lo]);
    assign ctr_msb_o = ctr_q[lookup_index_i][1];

    // full compare for the allocation decision
    assign upd.upd_tag_hit = (tag_q[upd.upd_index] == upd.upd_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= bpu_pkg::ctr_weak_nt;
            end
        end else if (upd.train) begin
            ctr_q[upd.upd_index] <= bpu_pkg::ctr_step(ctr_q[upd.upd_index], upd.upd_taken);
        end else if (upd.set_strong) begin
            ctr_q[upd.upd_index] <= upd.upd_taken ? 2'b11 : 2'b00;
        end else if (upd.allocate) begin
            tag_q[upd.upd_index] <= upd.upd_tag;
            ctr_q[upd.upd_index] <= upd.upd_taken ? 2'b10 : 2'b01;  // weak toward outcome
        end
    end

    a_cmd_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({upd.train, upd.set_strong, upd.allocate}));

endmodule

// ==== logic/btb.sv ====
module btb #(
    parameter int entries = bpu_pkg::default_btb_entries
) (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o,
    input  logic           upd_valid_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  bpu_pkg::addr_t upd_target_i
);

    logic [entries-1:0] valid_q;
    bpu_pkg::btb_tag_t  tag_q    [entries];
    bpu_pkg::addr_t     target_q [entries];
    bpu_pkg::btb_idx_t  rd_idx, wr_idx;

    assign rd_idx = bpu_pkg::btb_index(lookup_pc_i);
    assign wr_idx = bpu_pkg::btb_index(upd_pc_i);

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == bpu_pkg::btb_tag(lookup_pc_i));
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= '0;
        else if (upd_valid_i)
            valid_q[wr_idx] <= 1'b1;
    end

    // tag and target just follow the last taken update
    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            tag_q[wr_idx]    <= bpu_pkg::btb_tag(upd_pc_i);
            target_q[wr_idx] <= upd_target_i;
        end
    end

endmodule

// ==== logic/ras.sv ====
module ras #(
    parameter int depth = bpu_pkg::default_ras_depth
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::addr_t push_data_i,
    input  logic           pop_i,
    output bpu_pkg::addr_t top_o,
    output logic           nonempty_o
);

    localparam int ptr_w = $clog2(depth + 1);
    localparam int idx_w = $clog2(depth);

    bpu_pkg::addr_t   stack_q [depth];
    logic [ptr_w-1:0] ptr_q;       // next free slot
    logic [ptr_w-1:0] top_ptr;
    logic [ptr_w-1:0] popped_ptr;  // pointer after an optional pop
    logic             do_push;

    assign nonempty_o = (ptr_q != '0);
    assign top_ptr    = ptr_q - 1'b1;
    assign top_o      = stack_q[top_ptr[idx_w-1:0]];

    // pop first, then push lands on the popped slot
    assign popped_ptr = (pop_i && nonempty_o) ? top_ptr : ptr_q;
    assign do_push    = push_i && (popped_ptr < ptr_w'(depth));   // full stack drops it

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ptr_q <= '0;
        else
            ptr_q <= do_push ? popped_ptr + 1'b1 : popped_ptr;
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack_q[popped_ptr[idx_w-1:0]] <= push_data_i;
    end

    a_ptr_bound: assert property (@(posedge clk) disable iff (rst)
        ptr_q <= ptr_w'(depth));

endmodule

// ==== logic/bpu_ctrl.sv ====
module bpu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::addr_t      if_pc_i,
    input  bpu_pkg::addr_t      if_inst_i,
    input  logic                ex_branch_valid_i,
    input  logic                ex_branch_taken_i,
    input  logic                ex_pdt_true_i,
    input  bpu_pkg::addr_t      ex_pc_i,
    input  bpu_pkg::hist_t      ex_history_i,
    input  bpu_pkg::provider_e  ex_provider_i,
    input  bpu_pkg::addr_t      ex_target_i,
    input  bpu_pkg::addr_t      ex_inst_i,
    input  logic                id_ras_push_valid_i,
    input  bpu_pkg::addr_t      id_ras_push_data_i,
    input  logic                ex_stall_valid_i,
    output logic                branch_o,
    output bpu_pkg::addr_t      pdt_pc_o,
    output logic                pdt_res_o,
    output bpu_pkg::hist_t      history_o,
    output bpu_pkg::provider_e  provider_o,
    output bpu_pkg::bidx_t      base_lookup_index_o,
    input  logic                base_ctr_msb_i,
    output bpu_pkg::tidx_t      t0_lookup_index_o,
    output bpu_pkg::tag_t       t0_lookup_tag_o,
    input  logic                t0_hit_i,
    input  logic                t0_ctr_msb_i,
    output bpu_pkg::tidx_t      t1_lookup_index_o,
    output bpu_pkg::tag_t       t1_lookup_tag_o,
    input  logic                t1_hit_i,
    input  logic                t1_ctr_msb_i,
    output logic                base_upd_valid_o,
    output bpu_pkg::bidx_t      base_upd_index_o,
    output logic                base_upd_taken_o,
    tage_upd_if.ctrl            t0_upd,
    tage_upd_if.ctrl            t1_upd,
    output bpu_pkg::addr_t      btb_lookup_pc_o,
    input  logic                btb_hit_i,
    input  bpu_pkg::addr_t      btb_target_i,
    output logic                btb_upd_valid_o,
    output bpu_pkg::addr_t      btb_upd_pc_o,
    output bpu_pkg::addr_t      btb_upd_target_o,
    output logic                ras_push_o,
    output bpu_pkg::addr_t      ras_push_data_o,
    output logic                ras_pop_o,
    input  bpu_pkg::addr_t      ras_top_i,
    input  logic                ras_nonempty_i
);

    bpu_pkg::hist_t hist_q;
    bpu_pkg::addr_t b_imm, j_imm, pc_plus4;
    logic           is_branch, is_jal, is_jalr, is_ret, ex_is_ret, dir_taken;
    logic           miss_base;

    // ret is jalr x0, 0(x1) or jalr x0, 0(x5)
    assign is_branch = (if_inst_i[6:0] == bpu_pkg::op_branch);
    assign is_jal    = (if_inst_i[6:0] == bpu_pkg::op_jal);
    assign is_jalr   = (if_inst_i[6:0] == bpu_pkg::op_jalr);
    assign is_ret    = is_jalr && (if_inst_i[11:7] == 5'd0) && (if_inst_i[31:20] == 12'd0) &&
                       (if_inst_i[19:15] == 5'd1 || if_inst_i[19:15] == 5'd5);
    assign ex_is_ret = (ex_inst_i[6:0] == bpu_pkg::op_jalr) && (ex_inst_i[11:7] == 5'd0) &&
                       (ex_inst_i[31:20] == 12'd0) &&
                       (ex_inst_i[19:15] == 5'd1 || ex_inst_i[19:15] == 5'd5);

    assign b_imm    = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign j_imm    = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                       if_inst_i[30:21], 1'b0};
    assign pc_plus4 = if_pc_i + 32'd4;

    // lookup side
    assign base_lookup_index_o = bpu_pkg::base_index(if_pc_i);
    assign t0_lookup_index_o   = bpu_pkg::t0_index(if_pc_i, hist_q);
    assign t0_lookup_tag_o     = bpu_pkg::t0_tag(if_pc_i, hist_q);
    assign t1_lookup_index_o   = bpu_pkg::t1_index(if_pc_i, hist_q);
    assign t1_lookup_tag_o     = bpu_pkg::t1_tag(if_pc_i, hist_q);
    assign btb_lookup_pc_o     = if_pc_i;

    assign provider_o = t1_hit_i ? bpu_pkg::prov_t1 : t0_hit_i ? bpu_pkg::prov_t0
                                                               : bpu_pkg::prov_base;
    assign dir_taken  = t1_hit_i ? t1_ctr_msb_i : t0_hit_i ? t0_ctr_msb_i : base_ctr_msb_i;

    always_comb begin
        branch_o  = 1'b0;
        pdt_res_o = 1'b0;
        pdt_pc_o  = pc_plus4;
        if (is_branch || is_jal || is_jalr) begin
            branch_o = 1'b1;
            if (is_ret) begin
                pdt_res_o = ras_nonempty_i;     // empty stack falls through
                if (ras_nonempty_i)
                    pdt_pc_o = ras_top_i;
            end else if (is_jal) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = btb_hit_i ? btb_target_i : if_pc_i + j_imm;
            end else begin
                pdt_res_o = dir_taken;
                if (dir_taken && btb_hit_i)
                    pdt_pc_o = btb_target_i;
                else if (dir_taken && is_branch)
                    pdt_pc_o = if_pc_i + b_imm;
            end
        end
    end

    // base table trains on every resolved branch
    assign base_upd_valid_o = ex_branch_valid_i;
    assign base_upd_index_o = bpu_pkg::base_index(ex_pc_i);
    assign base_upd_taken_o = ex_branch_taken_i;

    assign t0_upd.upd_index = bpu_pkg::t0_index(ex_pc_i, ex_history_i);
    assign t0_upd.upd_tag   = bpu_pkg::t0_tag(ex_pc_i, ex_history_i);
    assign t0_upd.upd_taken = ex_branch_taken_i;
    assign t1_upd.upd_index = bpu_pkg::t1_index(ex_pc_i, ex_history_i);
    assign t1_upd.upd_tag   = bpu_pkg::t1_tag(ex_pc_i, ex_history_i);
    assign t1_upd.upd_taken = ex_branch_taken_i;

    assign miss_base = ex_branch_valid_i && !ex_pdt_true_i && ex_provider_i == bpu_pkg::prov_base;

    assign t0_upd.train      = ex_branch_valid_i && ex_pdt_true_i &&
                               ex_provider_i == bpu_pkg::prov_t0;
    assign t1_upd.train      = ex_branch_valid_i && ex_pdt_true_i &&
                               ex_provider_i == bpu_pkg::prov_t1;
    assign t0_upd.set_strong = ex_branch_valid_i && !ex_pdt_true_i &&
                               ex_provider_i == bpu_pkg::prov_t0;
    assign t1_upd.set_strong = ex_branch_valid_i && !ex_pdt_true_i &&
                               ex_provider_i == bpu_pkg::prov_t1;
    assign t1_upd.allocate   = miss_base && !t1_upd.upd_tag_hit;    // t1 first
    assign t0_upd.allocate   = miss_base && t1_upd.upd_tag_hit && !t0_upd.upd_tag_hit;

    assign btb_upd_valid_o  = ex_branch_valid_i && ex_branch_taken_i;
    assign btb_upd_pc_o     = ex_pc_i;
    assign btb_upd_target_o = ex_target_i;

    assign ras_push_o      = id_ras_push_valid_i && !ex_stall_valid_i;
    assign ras_push_data_o = id_ras_push_data_i;
    assign ras_pop_o       = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret &&
                             !ex_stall_valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            hist_q <= '0;
        else if (ex_branch_valid_i)
            hist_q <= {hist_q[bpu_pkg::hist_w-2:0], ex_branch_taken_i};
    end

    assign history_o = hist_q;

    a_res_needs_branch: assert property (@(posedge clk) disable iff (rst)
        pdt_res_o |-> branch_o);

endmodule

// ==== logic/bpu_top.sv ====
module bpu_top #(
    parameter int base_entries   = bpu_pkg::default_base_entries,
    parameter int tagged_entries = bpu_pkg::default_tagged_entries,
    parameter int btb_entries    = bpu_pkg::default_btb_entries,
    parameter int ras_depth      = bpu_pkg::default_ras_depth
) (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     if_pc_i,
    input  bpu_pkg::addr_t     if_inst_i,
    input  logic               ex_branch_valid_i,
    input  logic               ex_branch_taken_i,
    input  logic               ex_pdt_true_i,
    input  bpu_pkg::addr_t     ex_pc_i,
    input  bpu_pkg::hist_t     ex_history_i,
    input  bpu_pkg::provider_e ex_provider_i,
    input  bpu_pkg::addr_t     ex_target_i,
    input  bpu_pkg::addr_t     ex_inst_i,
    input  logic               id_ras_push_valid_i,
    input  bpu_pkg::addr_t     id_ras_push_data_i,
    input  logic               ex_stall_valid_i,
    output logic               branch_o,
    output bpu_pkg::addr_t     pdt_pc_o,
    output logic               pdt_res_o,
    output bpu_pkg::hist_t     history_o,
    output bpu_pkg::provider_e provider_o
);

    bpu_pkg::bidx_t base_lookup_index, base_upd_index;
    bpu_pkg::tidx_t t0_lookup_index, t1_lookup_index;
    bpu_pkg::tag_t  t0_lookup_tag, t1_lookup_tag;
    bpu_pkg::addr_t btb_lookup_pc, btb_target, btb_upd_pc, btb_upd_target;
    bpu_pkg::addr_t ras_push_data, ras_top;
    logic           base_ctr_msb, base_upd_valid, base_upd_taken;
    logic           t0_hit, t0_ctr_msb, t1_hit, t1_ctr_msb;
    logic           btb_hit, btb_upd_valid;
    logic           ras_push, ras_pop, ras_nonempty;

    tage_upd_if t0_upd ();
    tage_upd_if t1_upd ();

    // top-level ports and the two update interfaces connect by name
    bpu_ctrl u_ctrl (
        .*,
        .base_lookup_index_o(base_lookup_index), .base_ctr_msb_i(base_ctr_msb),
        .t0_lookup_index_o(t0_lookup_index), .t0_lookup_tag_o(t0_lookup_tag),
        .t0_hit_i(t0_hit), .t0_ctr_msb_i(t0_ctr_msb),
        .t1_lookup_index_o(t1_lookup_index), .t1_lookup_tag_o(t1_lookup_tag),
        .t1_hit_i(t1_hit), .t1_ctr_msb_i(t1_ctr_msb),
        .base_upd_valid_o(base_upd_valid), .base_upd_index_o(base_upd_index),
        .base_upd_taken_o(base_upd_taken),
        .btb_lookup_pc_o(btb_lookup_pc), .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .btb_upd_valid_o(btb_upd_valid), .btb_upd_pc_o(btb_upd_pc),
        .btb_upd_target_o(btb_upd_target),
        .ras_push_o(ras_push), .ras_push_data_o(ras_push_data), .ras_pop_o(ras_pop),
        .ras_top_i(ras_top), .ras_nonempty_i(ras_nonempty)
    );

    tage_base_table #(.entries(base_entries)) u_base (
        .clk, .rst,
        .lookup_index_i(base_lookup_index), .ctr_msb_o(base_ctr_msb),
        .upd_valid_i(base_upd_valid), .upd_index_i(base_upd_index),
        .upd_taken_i(base_upd_taken)
    );

    tage_tagged_table #(.entries(tagged_entries)) u_t0 (
        .clk, .rst,
        .lookup_index_i(t0_lookup_index), .lookup_tag_i(t0_lookup_tag),
        .hit_o(t0_hit), .ctr_msb_o(t0_ctr_msb), .upd(t0_upd)
    );

    tage_tagged_table #(.entries(tagged_entries)) u_t1 (
        .clk, .rst,
        .lookup_index_i(t1_lookup_index), .lookup_tag_i(t1_lookup_tag),
        .hit_o(t1_hit), .ctr_msb_o(t1_ctr_msb), .upd(t1_upd)
    );

    btb #(.entries(btb_entries)) u_btb (
        .clk, .rst,
        .lookup_pc_i(btb_lookup_pc), .hit_o(btb_hit), .target_o(btb_target),
        .upd_valid_i(btb_upd_valid), .upd_pc_i(btb_upd_pc), .upd_target_i(btb_upd_target)
    );

    ras #(.depth(ras_depth)) u_ras (
        .clk, .rst,
        .push_i(ras_push), .push_data_i(ras_push_data), .pop_i(ras_pop),
        .top_o(ras_top), .nonempty_o(ras_nonempty)
    );

endmodule

// ==== bench/bpu_tb_table.svh ====
// each row holds fetch pc, fetch instruction, expected {branch_o, pdt_res_o}, pdt_pc_o,
// provider_o, history_o, then {ex valid, taken, correct, id push, stall}, ex pc,
// ex history, ex provider, ex target, ex instruction, push data
// the ex and id columns act at the edge after the row is checked

localparam bpu_pkg::addr_t     alu_i  = 32'h0010_0093;   // addi x1, x0, 1
localparam bpu_pkg::addr_t     jal_i  = 32'h1000_00ef;   // jal x1, +256
localparam bpu_pkg::addr_t     beq_i  = 32'h0020_8863;   // beq x1, x2, +16
localparam bpu_pkg::addr_t     ret_i  = 32'h0000_8067;   // jalr x0, 0(x1)
localparam bpu_pkg::provider_e p_base = bpu_pkg::prov_base;
localparam bpu_pkg::provider_e p_t1   = bpu_pkg::prov_t1;

// pc[17] set keeps the partial tags clear of the reset tags while history stays small
task automatic load_rows();
    bpu_pkg::addr_t pc_j, pc_b, pc_t, pc_r, tgt_j;
    bpu_pkg::addr_t pc_n0, pc_n1, pc_n2, ret_a, ret_b;
    pc_j  = 32'h0002_1000;
    pc_b  = 32'h0002_2040;
    pc_t  = 32'h0003_4080;
    pc_r  = 32'h0002_5100;
    tgt_j = 32'h0004_0000;   // away from pc + j-imm
    pc_n0 = rand_pc();
    pc_n1 = rand_pc();
    pc_n2 = rand_pc();
    ret_a = rand_pc();
    ret_b = rand_pc();

    // alu, then jal before and after its btb entry
    add_row('{pc_n0, alu_i, 2'b00, pc_n0 + 4, p_base, '0, '0, '0, '0, p_base, '0, '0, '0});
    add_row('{pc_j, jal_i, 2'b11, pc_j + 256, p_base, '0,
              5'b11100, pc_j, '0, p_base, tgt_j, jal_i, '0});
    add_row('{pc_j, jal_i, 2'b11, tgt_j, p_base, 16'h0001, '0, '0, '0, p_base, '0, '0, '0});
    // bimodal counter 01, 10, 11
    add_row('{pc_b, beq_i, 2'b10, pc_b + 4, p_base, 16'h0001,
              5'b11100, pc_b, 16'h0001, p_base, pc_b + 16, beq_i, '0});
    add_row('{pc_b, beq_i, 2'b11, pc_b + 16, p_base, 16'h0003,
              5'b11100, pc_b, 16'h0003, p_base, pc_b + 16, beq_i, '0});
    // pc_b + 400h shares the counter but not the btb tag and takes pc + b-imm
    // base miss at pc_t under the history the next lookup sees
    add_row('{pc_b + 32'h400, beq_i, 2'b11, pc_b + 32'h400 + 16, p_base, 16'h0007,
              5'b11000, pc_t, 16'h000f, p_base, pc_t + 16, beq_i, '0});
    add_row('{pc_t, beq_i, 2'b11, pc_t + 16, p_t1, 16'h000f, '0, '0, '0, p_base, '0, '0, '0});
    // push, stalled push, pop on a taken ex ret, then empty stack
    add_row('{pc_n1, alu_i, 2'b00, pc_n1 + 4, p_base, 16'h000f,
              5'b00010, '0, '0, p_base, '0, '0, ret_a});
    add_row('{pc_r, ret_i, 2'b11, ret_a, p_base, 16'h000f,
              5'b00011, '0, '0, p_base, '0, '0, ret_b});
    add_row('{pc_r, ret_i, 2'b11, ret_a, p_base, 16'h000f,
              5'b11100, pc_r, 16'h000f, p_base, ret_a, ret_i, '0});
    // history takes a not-taken then a taken outcome
    add_row('{pc_r, ret_i, 2'b10, pc_r + 4, p_base, 16'h001f,
              5'b10100, pc_b, 16'h001f, p_base, '0, beq_i, '0});
    add_row('{pc_n2, alu_i, 2'b00, pc_n2 + 4, p_base, 16'h003e,
              5'b11100, pc_j, 16'h003e, p_base, tgt_j, jal_i, '0});
    add_row('{pc_j, jal_i, 2'b11, tgt_j, p_base, 16'h007d, '0, '0, '0, p_base, '0, '0, '0});
endtask

// ==== bench/bpu_tb.sv ====
module bpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        bpu_pkg::addr_t     if_pc, if_inst;
        logic [1:0]         exp_flags;        // branch_o, pdt_res_o
        bpu_pkg::addr_t     exp_pc;
        bpu_pkg::provider_e exp_prov;
        bpu_pkg::hist_t     exp_hist;
        logic [4:0]         ctl;              // ex valid, taken, correct, id push, stall
        bpu_pkg::addr_t     ex_pc;
        bpu_pkg::hist_t     ex_hist;
        bpu_pkg::provider_e ex_prov;
        bpu_pkg::addr_t     ex_target, ex_inst;
        bpu_pkg::addr_t     push_data;
    } row_t;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               ex_branch_valid_i, ex_branch_taken_i, ex_pdt_true_i;
    logic               id_ras_push_valid_i, ex_stall_valid_i;
    logic               branch_o, pdt_res_o;
    bpu_pkg::addr_t     if_pc_i, if_inst_i, ex_pc_i, ex_target_i, ex_inst_i;
    bpu_pkg::addr_t     id_ras_push_data_i, pdt_pc_o;
    bpu_pkg::hist_t     ex_history_i, history_o;
    bpu_pkg::provider_e ex_provider_i, provider_o;
    row_t               rows [$];
    row_t               cur;                  // row currently on the inputs
    integer             seed = 48;
    int                 errors = 0;
    bit                 rows_ready = 1'b0;

    bpu_top uut (.*);

    always #50 clk = ~clk;

    assign if_pc_i             = cur.if_pc;
    assign if_inst_i           = cur.if_inst;
    assign ex_branch_valid_i   = cur.ctl[4];
    assign ex_branch_taken_i   = cur.ctl[3];
    assign ex_pdt_true_i       = cur.ctl[2];
    assign id_ras_push_valid_i = cur.ctl[1];
    assign ex_stall_valid_i    = cur.ctl[0];
    assign ex_pc_i             = cur.ex_pc;
    assign ex_history_i        = cur.ex_hist;
    assign ex_provider_i       = cur.ex_prov;
    assign ex_target_i         = cur.ex_target;
    assign ex_inst_i           = cur.ex_inst;
    assign id_ras_push_data_i  = cur.push_data;

    // word aligned with pc[17:16] at 10 so no tagged entry matches
    function automatic bpu_pkg::addr_t rand_pc();
        return (32'($random(seed)) & 32'h0000_fffc) | 32'h0002_0000;
    endfunction

    task automatic add_row(input row_t r);
        rows.push_back(r);
    endtask

    task automatic check_value(input int row, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: row %0d %s is %h, expected %h",
                     $time, row, name, got, exp);
        end
    endtask

    `include "bpu_tb_table.svh"

    initial begin
        cur = '{32'h0, 32'h0, 2'b00, 32'h0, bpu_pkg::prov_base, 16'h0,
                5'b00000, 32'h0, 16'h0, bpu_pkg::prov_base, 32'h0, 32'h0, 32'h0};
        load_rows();
        rows_ready = 1'b1;
        repeat (3) @(posedge clk);
        #5 rst = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #5 cur = rows[i];
            #85;   // outputs settled, next edge still ahead
            check_value(i, "branch_o", 32'(branch_o), 32'(cur.exp_flags[1]));
            check_value(i, "pdt_res_o", 32'(pdt_res_o), 32'(cur.exp_flags[0]));
            check_value(i, "pdt_pc_o", pdt_pc_o, cur.exp_pc);
            check_value(i, "provider_o", 32'(provider_o), 32'(cur.exp_prov));
            check_value(i, "history_o", 32'(history_o), 32'(cur.exp_hist));
        end
        $display("%0d rows checked, %0d errors", rows.size(), errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // ends the run at twice the time the rows plus some slack should take
    initial begin
        wait (rows_ready);
        #((rows.size() + 10) * 100 * 2);
        $display("watchdog expired before all %0d table rows were applied", rows.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+bench
common/bpu_pkg.sv
common/tage_upd_if.sv
tage/tage_base_table.sv
tage/tage_tagged_table.sv
logic/btb.sv
logic/ras.sv
logic/bpu_ctrl.sv
logic/bpu_top.sv
bench/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it, pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module bpu_tb -f filelist.f

out=$(./obj_dir/Vbpu_tb)
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"
